// ==== list.f ====
micro_risc_pkg.sv
reg_file.sv
alu.sv
branch_cond.sv
pc_unit.sv
exec_core.sv
tb_exec_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_exec_core -o sim_exec_core
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/sim_exec_core)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# Pass only when the testbench reported it
if grep -q "TEST PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1

// ==== tb_exec_core.sv ====
`timescale 1ns/10ps

module tb_exec_core
	import micro_risc_pkg::*;
();

	localparam logic [31:0] lcg_seed = 32'h7c08;
	localparam int reset_cycles   = 3;
	localparam int sweep_per_code = 16;
	localparam int num_random     = 1000;
	localparam int reload_every   = 200;
	// Cycles driven by each phase, plus a short tail
	localparam int run_cycles = reset_cycles + num_regs + (num_regs - 1)
		+ num_regs * (sweep_per_code + sweep_per_code / 4)
		+ num_random + (num_random / reload_every) * (num_regs - 1) + 2;
	localparam int cycle_limit = run_cycles + run_cycles / 2;

	// DUT inputs
	logic                  clk;
	logic                  rst_n;
	logic                  valid;
	instr_class_t          instr_class;
	alu_op_t               alu_op;
	cmp_op_t               cmp_op;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic                  use_imm;
	logic [data_w-1:0]     imm;
	logic [offset_w-1:0]   offset;

	// DUT outputs
	logic [pc_w-1:0]       pc;
	logic                  carry;
	logic                  wb_en;
	logic [reg_addr_w-1:0] wb_addr;
	logic [data_w-1:0]     wb_data;
	logic                  taken;

	// Reference model state
	logic [data_w-1:0]     m_regs [0:num_regs-1];
	logic                  m_carry;
	logic [pc_w-1:0]       m_pc;
	logic                  state_known = 1'b0;

	// Expected values for the current cycle
	logic [data_w-1:0]     exp_rs;
	logic [data_w-1:0]     exp_rt;
	logic [data_w:0]       exp_alu;
	logic                  exp_cond;
	logic                  exp_wb_en;
	logic                  exp_taken;
	logic [pc_w-1:0]       exp_next_pc;

	logic [31:0]           lcg_state = lcg_seed;
	int                    errors = 0;
	int                    checks = 0;
	int                    cycles = 0;

	exec_core u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid       (valid),
		.instr_class (instr_class),
		.alu_op      (alu_op),
		.cmp_op      (cmp_op),
		.rd          (rd),
		.rs          (rs),
		.rt          (rt),
		.use_imm     (use_imm),
		.imm         (imm),
		.offset      (offset),
		.pc          (pc),
		.carry       (carry),
		.wb_en       (wb_en),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.taken       (taken)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// Random source
	// ------------------------------

	// Two LCG steps, upper halves only
	function automatic logic [31:0] next_random();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {hi, lcg_state[31:16]};
	endfunction

	// Biased toward edge values
	function automatic logic [31:0] corner_word();
		logic [31:0] r;
		r = next_random();
		case (r[2:0])
			3'd0:    return 32'h0000_0000;
			3'd1:    return 32'hffff_ffff;
			3'd2:    return 32'h8000_0000;
			3'd3:    return 32'h7fff_ffff;
			3'd4:    return 32'h0000_0001;
			default: return next_random();
		endcase
	endfunction

	// ------------------------------
	// Reference model
	// ------------------------------

	// Returns carry in bit 32; shifts step one bit at a time
	function automatic logic [32:0] model_alu(alu_op_t op, logic [31:0] a, logic [31:0] b);
		logic [31:0] v;
		logic        cy;
		int          n;
		n  = int'(b[4:0]);
		v  = a;
		cy = 1'b0;
		case (op)
			alu_add: return {1'b0, a} + {1'b0, b};
			alu_sub: return {(a >= b), a - b};
			alu_and: return {1'b0, a & b};
			alu_or:  return {1'b0, a | b};
			alu_xor: return {1'b0, a ^ b};
			alu_shl:
			begin
				for (int i = 0; i < n; i++)
				begin
					cy = v[31];
					v  = {v[30:0], 1'b0};
				end
				return {cy, v};
			end
			alu_shr:
			begin
				for (int i = 0; i < n; i++)
				begin
					cy = v[0];
					v  = {1'b0, v[31:1]};
				end
				return {cy, v};
			end
			default: return {1'b0, b};
		endcase
	endfunction

	// Plain names unsigned, s suffix signed
	function automatic logic model_cond(cmp_op_t op, logic [31:0] a, logic [31:0] b, logic cy);
		case (op)
			cmp_eq:   return a == b;
			cmp_ne:   return a != b;
			cmp_c:    return cy;
			cmp_nc:   return !cy;
			cmp_z:    return a == 32'd0;
			cmp_nz:   return a != 32'd0;
			cmp_lt:   return a < b;
			cmp_nlt:  return a >= b;
			cmp_lts:  return $signed(a) < $signed(b);
			cmp_nlts: return $signed(a) >= $signed(b);
			cmp_gt:   return a > b;
			cmp_ngt:  return a <= b;
			cmp_gts:  return $signed(a) > $signed(b);
			cmp_ngts: return $signed(a) <= $signed(b);
			default:  return 1'b0;
		endcase
	endfunction

	always_comb
	begin
		exp_rs    = m_regs[rs];
		exp_rt    = m_regs[rt];
		exp_alu   = model_alu(alu_op, exp_rs, use_imm ? imm : exp_rt);
		exp_cond  = model_cond(cmp_op, exp_rs, exp_rt, m_carry);
		exp_wb_en = rst_n && valid && (instr_class == cls_alu);
		exp_taken = rst_n && valid &&
			((instr_class == cls_jr) || ((instr_class == cls_branch) && exp_cond));
		if (exp_taken && (instr_class == cls_jr))
			exp_next_pc = exp_rs[15:0];
		else if (exp_taken)
			exp_next_pc = m_pc + 16'd1 + offset;
		else
			exp_next_pc = m_pc + 16'd1;
	end

	// Architectural update on each rising edge
	always @(posedge clk)
	begin
		checks <= checks + (state_known ? 6 : 4);
		state_known <= 1'b1;
		if (!rst_n)
		begin
			for (int i = 0; i < num_regs; i++)
				m_regs[i] <= 32'd0;
			m_carry <= 1'b0;
			m_pc    <= 16'd0;
		end
		else
		begin
			if (exp_wb_en)
			begin
				if (rd != 4'd0)
					m_regs[rd] <= exp_alu[31:0];
				m_carry <= exp_alu[32];
			end
			m_pc <= exp_next_pc;
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("[FAIL] %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
	endtask

	assert property (@(posedge clk) wb_en == exp_wb_en)
		else report_mismatch("wb_en", 32'($sampled(wb_en)), 32'($sampled(exp_wb_en)));
	assert property (@(posedge clk) !exp_wb_en || (wb_addr == rd))
		else report_mismatch("wb_addr", 32'($sampled(wb_addr)), 32'($sampled(rd)));
	assert property (@(posedge clk) !exp_wb_en || (wb_data == exp_alu[31:0]))
		else report_mismatch("wb_data", $sampled(wb_data), $sampled(exp_alu[31:0]));
	assert property (@(posedge clk) taken == exp_taken)
		else report_mismatch("taken", 32'($sampled(taken)), 32'($sampled(exp_taken)));
	// State is unknown until the first reset edge
	assert property (@(posedge clk) disable iff (!state_known) carry == m_carry)
		else report_mismatch("carry", 32'($sampled(carry)), 32'($sampled(m_carry)));
	assert property (@(posedge clk) disable iff (!state_known) pc == m_pc)
		else report_mismatch("pc", 32'($sampled(pc)), 32'($sampled(m_pc)));

	// ------------------------------
	// Stimulus
	// ------------------------------

	// One instruction per falling edge
	task automatic drive_instr(input logic v, input instr_class_t cls, input alu_op_t aop,
		input cmp_op_t cop, input logic [3:0] d, input logic [3:0] s, input logic [3:0] t,
		input logic ui, input logic [31:0] im, input logic [15:0] off);
		@(negedge clk);
		valid       = v;
		instr_class = cls;
		alu_op      = aop;
		cmp_op      = cop;
		rd          = d;
		rs          = s;
		rt          = t;
		use_imm     = ui;
		imm         = im;
		offset      = off;
	endtask

	task automatic drive_random_instr();
		logic [31:0]  r;
		logic [31:0]  o;
		instr_class_t cls;
		r = next_random();
		o = next_random();
		// Mostly alu and branches, some jr, nop and idle
		if (r[3:0] < 4'd7)
			cls = cls_alu;
		else if (r[3:0] < 4'd12)
			cls = cls_branch;
		else if (r[3:0] == 4'd12)
			cls = cls_jr;
		else
			cls = cls_nop;
		drive_instr(r[3:0] < 4'd14, cls, alu_op_t'(o[6:4]), cmp_op_t'(o[11:8]), o[15:12],
			o[3:0], o[12] ? o[3:0] : o[27:24], o[7], corner_word(),
			{{11{o[20]}}, o[20:16]});
	endtask

	// Fill r1 to r15 with edge values
	task automatic load_corner_regs();
		for (int i = 1; i < num_regs; i++)
			drive_instr(1'b1, cls_alu, alu_pass_b, cmp_eq, 4'(i), 4'd0, 4'd0, 1'b1,
				corner_word(), 16'd0);
	endtask

	initial
	begin
		rst_n       = 1'b0;
		valid       = 1'b0;
		instr_class = cls_nop;
		alu_op      = alu_add;
		cmp_op      = cmp_eq;
		rd          = 4'd0;
		rs          = 4'd0;
		rt          = 4'd0;
		use_imm     = 1'b0;
		imm         = 32'd0;
		offset      = 16'd0;

		// Instructions under reset must not write or redirect
		drive_instr(1'b1, cls_alu, alu_pass_b, cmp_eq, 4'd1, 4'd0, 4'd0, 1'b1,
			32'hffff_ffff, 16'd0);
		drive_instr(1'b1, cls_jr, alu_add, cmp_eq, 4'd0, 4'd1, 4'd0, 1'b0, 32'd0, 16'd0);
		drive_instr(1'b0, cls_nop, alu_add, cmp_eq, 4'd0, 4'd0, 4'd0, 1'b0, 32'd0, 16'd0);
		rst_n = 1'b1;

		// First read of every register, result sent to r0
		for (int i = 0; i < num_regs; i++)
			drive_instr(1'b1, cls_alu, alu_or, cmp_eq, 4'd0, 4'(i), 4'd0, 1'b1, 32'd0, 16'd0);
		load_corner_regs();

		// Every code, including reserved ones, on mixed operand pairs
		for (int code = 0; code < 16; code++)
		begin
			for (int k = 0; k < sweep_per_code; k++)
			begin
				logic [31:0] o;
				o = next_random();
				// Refresh carry and one register every fourth branch
				if (k % 4 == 0)
					drive_instr(1'b1, cls_alu, alu_op_t'(o[31:29]),
						cmp_eq, o[19:16], o[23:20], 4'd0, 1'b1, corner_word(), 16'd0);
				drive_instr(1'b1, cls_branch, alu_add, cmp_op_t'(code[3:0]), 4'd0, o[3:0],
					o[8] ? o[3:0] : o[7:4], 1'b0, 32'd0, {{10{o[15]}}, o[15:10]});
			end
		end

		// Random mix with periodic reloads
		for (int i = 0; i < num_random; i++)
		begin
			if (i % reload_every == 0)
				load_corner_regs();
			drive_random_instr();
		end

		// Let the last instruction reach its edge
		repeat (2)
			drive_instr(1'b0, cls_nop, alu_add, cmp_eq, 4'd0, 4'd0, 4'd0, 1'b0, 32'd0, 16'd0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Run limit
	initial
	begin
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycle_limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== exec_core.sv ====
`timescale 1ns/10ps

module exec_core
	import micro_risc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	// Pre-decoded instruction, one per cycle
	input  logic                  valid,
	input  instr_class_t          instr_class,
	input  alu_op_t               alu_op,
	input  cmp_op_t               cmp_op,
	input  logic [reg_addr_w-1:0] rd,
	input  logic [reg_addr_w-1:0] rs,
	input  logic [reg_addr_w-1:0] rt,
	input  logic                  use_imm,
	input  logic [data_w-1:0]     imm,
	input  logic [offset_w-1:0]   offset,
	// Architectural state
	output logic [pc_w-1:0]       pc,
	output logic                  carry,
	// Write-back of the current instruction
	output logic                  wb_en,
	output logic [reg_addr_w-1:0] wb_addr,
	output logic [data_w-1:0]     wb_data,
	// Current branch or jr redirects
	output logic                  taken
);

	// Operand path
	logic [data_w-1:0] rs_data;
	logic [data_w-1:0] rt_data;
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_result;
	logic              alu_carry;

	// Branch verdict
	logic              cond_true;

	// ------------------------------
	// Register file
	// ------------------------------

	reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (rs),
		.rt      (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb_en),
		.wa      (wb_addr),
		.wd      (wb_data)
	);

	// ------------------------------
	// Execute
	// ------------------------------

	// Immediate replaces rt as operand b
	assign alu_b = use_imm ? imm : rt_data;

	alu u_alu (
		.a         (rs_data),
		.b         (alu_b),
		.op        (alu_op),
		.result    (alu_result),
		.carry_out (alu_carry)
	);

	// Branches see the carry stored before this edge
	branch_cond u_branch_cond (
		.a         (rs_data),
		.b         (rt_data),
		.cmp_op    (cmp_op),
		.carry     (carry),
		.cond_true (cond_true)
	);

	// ------------------------------
	// Write-back and flags
	// ------------------------------

	// ALU class only, held low through reset
	assign wb_en   = rst_n && valid && (instr_class == cls_alu);
	assign wb_addr = rd;
	assign wb_data = alu_result;

	// Carry loads with each ALU write-back
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			carry <= 1'b0;
		else if (wb_en)
			carry <= alu_carry;
	end

	// ------------------------------
	// Program counter
	// ------------------------------

	pc_unit u_pc_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.valid       (valid),
		.instr_class (instr_class),
		.cond_true   (cond_true),
		.offset      (offset),
		.jr_target   (rs_data[pc_w-1:0]),
		.pc          (pc),
		.taken       (taken)
	);

endmodule

// ==== pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit
	import micro_risc_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                valid,
	input  instr_class_t        instr_class,
	// Verdict from the condition evaluator
	input  logic                cond_true,
	// Signed word offset, relative to pc + 1
	input  logic [offset_w-1:0] offset,
	// Low bits of rs for jr
	input  logic [pc_w-1:0]     jr_target,
	output logic [pc_w-1:0]     pc,
	output logic                taken
);

	logic [pc_w-1:0] pc_inc;
	logic [pc_w-1:0] offset_ext;
	logic [pc_w-1:0] pc_next;
	logic            is_jr;
	logic            is_branch;

	// ------------------------------
	// Redirect decision
	// ------------------------------

	assign is_jr     = (instr_class == cls_jr);
	assign is_branch = (instr_class == cls_branch);

	// Held low through reset
	assign taken = rst_n && valid && (is_jr || (is_branch && cond_true));

	// ------------------------------
	// Next PC
	// ------------------------------

	assign pc_inc     = pc + 1'b1;
	assign offset_ext = pc_w'($signed(offset));

	always_comb
	begin
		if (taken && is_jr)
			pc_next = jr_target;
		else if (taken)
			pc_next = pc_inc + offset_ext;
		else
			// Idle, nop, alu and untaken branch
			pc_next = pc_inc;
	end

	// PC register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

endmodule

// ==== branch_cond.sv ====
`timescale 1ns/10ps

module branch_cond
	import micro_risc_pkg::*;
(
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,
	input  cmp_op_t           cmp_op,
	input  logic              carry,
	output logic              cond_true
);

	// Base relations, each formed once
	logic eq;
	logic z;
	logic lt;
	logic gt;
	logic lts;
	logic gts;

	// Sign bits agree
	logic same_sign;

	// ------------------------------
	// Relations
	// ------------------------------

	assign eq = (a == b);
	assign z  = (a == '0);

	// Unsigned order
	assign lt = (a < b);
	assign gt = !lt && !eq;

	assign same_sign = (a[data_w-1] == b[data_w-1]);

	// Signed less: negative a against non-negative b
	// otherwise low bits decide when signs match
	assign lts = (a[data_w-1] && !b[data_w-1]) ||
		(same_sign && (a[data_w-2:0] < b[data_w-2:0]));

	// Signed greater mirrors it
	assign gts = (!a[data_w-1] && b[data_w-1]) ||
		(same_sign && (a[data_w-2:0] > b[data_w-2:0]));

	// ------------------------------
	// Condition select
	// ------------------------------

	always_comb
	begin
		case (cmp_op)
			cmp_eq:   cond_true = eq;
			cmp_ne:   cond_true = !eq;
			cmp_c:    cond_true = carry;
			cmp_nc:   cond_true = !carry;
			cmp_z:    cond_true = z;
			cmp_nz:   cond_true = !z;
			// Plain forms are unsigned
			cmp_lt:   cond_true = lt;
			cmp_nlt:  cond_true = !lt;
			// S suffix is signed
			cmp_lts:  cond_true = lts;
			cmp_nlts: cond_true = !lts;
			cmp_gt:   cond_true = gt;
			cmp_ngt:  cond_true = !gt;
			cmp_gts:  cond_true = gts;
			cmp_ngts: cond_true = !gts;
			// Jump codes never taken here
			default:  cond_true = 1'b0;
		endcase
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/10ps

module alu
	import micro_risc_pkg::*;
(
	input  logic [data_w-1:0] a,
	input  logic [data_w-1:0] b,
	input  alu_op_t           op,
	output logic [data_w-1:0] result,
	output logic              carry_out
);

	// Shift amount from low bits of b
	logic [shamt_w-1:0] shamt;

	// Widened results with one spare bit for the carry
	logic [data_w:0]    sum_ext;
	logic [data_w:0]    shl_ext;
	logic [data_w:0]    shr_ext;

	assign shamt = b[shamt_w-1:0];

	// ------------------------------
	// Arithmetic and shifts
	// ------------------------------

	// 33rd bit is the add carry
	assign sum_ext = {1'b0, a} + {1'b0, b};

	// Left shift pushes the last bit out into bit 32
	// Zero amount leaves that bit clear
	assign shl_ext = {1'b0, a} << shamt;

	// Right shift pushes the last bit out into bit 0
	assign shr_ext = {a, 1'b0} >> shamt;

	// ------------------------------
	// Operation select
	// ------------------------------

	always_comb
	begin
		result    = '0;
		carry_out = 1'b0;
		case (op)
			alu_add:
			begin
				result    = sum_ext[data_w-1:0];
				carry_out = sum_ext[data_w];
			end
			alu_sub:
			begin
				// Carry means no borrow, a >= b unsigned
				result    = a - b;
				carry_out = (a >= b);
			end
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;
			alu_xor:
				result = a ^ b;
			alu_shl:
			begin
				result    = shl_ext[data_w-1:0];
				carry_out = shl_ext[data_w];
			end
			alu_shr:
			begin
				result    = shr_ext[data_w:1];
				carry_out = shr_ext[0];
			end
			alu_pass_b:
				result = b;
			default:
			begin
				result    = '0;
				carry_out = 1'b0;
			end
		endcase
	end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file
	import micro_risc_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	// Read port addresses
	input  logic [reg_addr_w-1:0] rs,
	input  logic [reg_addr_w-1:0] rt,
	// Read data, combinational
	output logic [data_w-1:0]     rs_data,
	output logic [data_w-1:0]     rt_data,
	// Write port
	input  logic                  we,
	input  logic [reg_addr_w-1:0] wa,
	input  logic [data_w-1:0]     wd
);

	// Register 0 has no storage
	logic [data_w-1:0] regs [1:num_regs-1];

	// ------------------------------
	// Write port
	// ------------------------------

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// Whole file cleared
			for (int i = 1; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (we && (wa != '0))
		begin
			// Writes to r0 are dropped
			regs[wa] <= wd;
		end
	end

	// ------------------------------
	// Read ports
	// ------------------------------

	// Index 0 reads as zero
	always_comb
	begin
		rs_data = (rs == '0) ? '0 : regs[rs];
		rt_data = (rt == '0) ? '0 : regs[rt];
	end

endmodule

// ==== micro_risc_pkg.sv ====
package micro_risc_pkg;

	// ------------------------------
	// Widths
	// ------------------------------

	// Data path and register file
	localparam int data_w     = 32;
	localparam int reg_addr_w = 4;
	localparam int num_regs   = 1 << reg_addr_w;

	// Shift amount taken from low bits of operand b
	localparam int shamt_w    = 5;

	// PC counts instruction words
	localparam int pc_w       = 16;
	localparam int offset_w   = 16;

	// ------------------------------
	// Branch conditions
	// ------------------------------

	// Codes 0 and 1 belong to unconditional jumps
	// Those are resolved by instruction class and evaluate false here
	typedef enum logic [3:0] {
		cmp_rsv_j  = 4'd0,
		cmp_rsv_jr = 4'd1,
		cmp_eq     = 4'd2,
		cmp_ne     = 4'd3,
		cmp_c      = 4'd4,
		cmp_nc     = 4'd5,
		cmp_z      = 4'd6,
		cmp_nz     = 4'd7,
		cmp_lt     = 4'd8,
		cmp_nlt    = 4'd9,
		cmp_lts    = 4'd10,
		cmp_nlts   = 4'd11,
		cmp_gt     = 4'd12,
		cmp_ngt    = 4'd13,
		cmp_gts    = 4'd14,
		cmp_ngts   = 4'd15
	} cmp_op_t;

	// ------------------------------
	// ALU operations
	// ------------------------------

	typedef enum logic [2:0] {
		alu_add    = 3'd0,
		alu_sub    = 3'd1,
		alu_and    = 3'd2,
		alu_or     = 3'd3,
		alu_xor    = 3'd4,
		alu_shl    = 3'd5,
		alu_shr    = 3'd6,
		alu_pass_b = 3'd7
	} alu_op_t;

	// ------------------------------
	// Instruction classes
	// ------------------------------

	typedef enum logic [1:0] {
		cls_alu    = 2'd0,
		cls_branch = 2'd1,
		cls_jr     = 2'd2,
		cls_nop    = 2'd3
	} instr_class_t;

endpackage
